// ==== list.f ====
+incdir+hw
hw/mips_pkg.sv
hw/alu_unit.sv
hw/shift_unit.sv
hw/exmem_reg.sv
hw/data_mem.sv
hw/ex_mem_top.sv
bench/ex_mem_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the EX/MEM testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary -j 0 \
    --top-module ex_mem_tb \
    -f list.f \
    -o ex_mem_sim

./obj_dir/ex_mem_sim

// ==== bench/ex_mem_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mips_config.svh"

module ex_mem_tb
    import mips_pkg::*;
();

    // Rough count of operations issued over all tests
    localparam int N_OPS      = 200;
    localparam int CLK_PERIOD = 8;

    logic                 clk;
    logic                 rst_n;
    logic                 halt;
    alu_op_e              alu_op;
    logic [`NB_DATA-1:0]  operand_a;
    logic [`NB_DATA-1:0]  operand_b;
    logic [4:0]           shamt;
    logic [`NB_DATA-1:0]  data4mem;
    logic                 mem2reg;
    logic                 mem_read;
    logic                 mem_write;
    logic                 reg_write;
    mem_width_e           width;
    logic                 sign_flag;
    logic                 reg_dst;
    logic [`NB_REG-1:0]   rd_num;
    logic [`NB_REG-1:0]   rt_num;
    logic [`NB_DATA-1:0]  wb_data;
    logic [`NB_REG-1:0]   write_reg;
    logic                 wb_reg_write;

    // Byte-addressed image of the data memory
    logic [7:0]           ref_bytes [4*`MEM_WORDS];

    ex_mem_top ex_mem_top_i (
        .clk         (clk),
        .i_rst_n     (rst_n),
        .i_halt      (halt),
        .i_alu_op    (alu_op),
        .i_operand_a (operand_a),
        .i_operand_b (operand_b),
        .i_shamt     (shamt),
        .i_data4mem  (data4mem),
        .i_mem2reg   (mem2reg),
        .i_mem_read  (mem_read),
        .i_mem_write (mem_write),
        .i_reg_write (reg_write),
        .i_width     (width),
        .i_sign_flag (sign_flag),
        .i_reg_dst   (reg_dst),
        .i_rd        (rd_num),
        .i_rt        (rt_num),
        .o_wb_data   (wb_data),
        .o_write_reg (write_reg),
        .o_reg_write (wb_reg_write)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Each operation needs far fewer than 10 cycles
    initial begin
        #(N_OPS * 10 * CLK_PERIOD);
        $display("=== FAIL ===");
        $fatal(1, "Simulation timed out before all tests finished");
    end

    function automatic logic [31:0] expected_exec(input alu_op_e op, input logic [31:0] a,
                                                  input logic [31:0] b, input logic [4:0] sh);
        logic [31:0] fill;
        fill = ~(32'hffff_ffff >> sh);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a + ~b + 32'd1;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_NOR:  return ~a & ~b;
            // Flipping the sign bits turns a signed compare into an unsigned one
            ALU_SLT:  return {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
            ALU_SLTU: return {31'b0, a < b};
            ALU_LUI:  return b << 16;
            ALU_SLL:  return b << sh;
            ALU_SRL:  return b >> sh;
            ALU_SRA:  return (b >> sh) | (b[31] ? fill : 32'h0);
            default:  return 32'h0;
        endcase
    endfunction

    function automatic int access_len(input mem_width_e w);
        return (w == W_BYTE) ? 1 : ((w == W_HALF) ? 2 : 4);
    endfunction

    function automatic void record_store(input logic [31:0] addr, input logic [31:0] data,
                                         input mem_width_e w);
        int base;
        int n;
        int i;
        n    = access_len(w);
        base = addr % (4 * `MEM_WORDS);
        base = base - (base % n);
        for (i = 0; i < n; i++) begin
            ref_bytes[base + i] = data[8*i +: 8];
        end
    endfunction

    function automatic logic [31:0] expected_load(input logic [31:0] addr, input mem_width_e w,
                                                  input logic sign);
        logic [31:0] val;
        int base;
        int n;
        int i;
        n    = access_len(w);
        base = addr % (4 * `MEM_WORDS);
        base = base - (base % n);
        val  = 32'h0;
        for (i = 0; i < n; i++) begin
            val[8*i +: 8] = ref_bytes[base + i];
        end
        if (sign && n < 4 && val[8*n-1]) begin
            val = val | (32'hffff_ffff << (8 * n));
        end
        return val;
    endfunction

    task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s got %h, expected %h", $time, what, actual, expected);
            $display("=== FAIL ===");
            $fatal(1, "Stopping on the first mismatch");
        end
    endtask

    task automatic check_outputs(input logic [31:0] data, input logic [4:0] wreg,
                                 input logic wr, input string what);
        check_eq(wb_data, data, {what, " data"});
        check_eq(32'(write_reg), 32'(wreg), {what, " write register"});
        check_eq(32'(wb_reg_write), 32'(wr), {what, " reg write"});
    endtask

    // Ends 1 ns after a rising edge, where new inputs are driven
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic clear_inputs();
        alu_op    = ALU_ADD;
        operand_a = '0;
        operand_b = '0;
        shamt     = '0;
        data4mem  = '0;
        mem2reg   = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        reg_write = 1'b0;
        width     = W_WORD;
        sign_flag = 1'b0;
        reg_dst   = 1'b0;
        rd_num    = '0;
        rt_num    = '0;
    endtask

    task automatic drive_alu(input alu_op_e op, input logic [31:0] a, input logic [31:0] b,
                             input logic [4:0] sh, input logic [4:0] rd);
        clear_inputs();
        alu_op    = op;
        operand_a = a;
        operand_b = b;
        shamt     = sh;
        reg_write = 1'b1;
        reg_dst   = 1'b1;
        rd_num    = rd;
        rt_num    = ~rd;
    endtask

    // Address comes from an ADD with operand B at zero, result goes to rt 9
    task automatic drive_mem(input logic store, input logic [31:0] addr,
                             input logic [31:0] data, input mem_width_e w, input logic sign);
        clear_inputs();
        operand_a = addr;
        data4mem  = data;
        mem_write = store;
        mem_read  = !store;
        mem2reg   = !store;
        reg_write = !store;
        width     = w;
        sign_flag = sign;
        rt_num    = 5'd9;
    endtask

    // Inputs are already driven, the result shows two edges later
    task automatic finish_op(input logic [31:0] data, input logic [4:0] wreg,
                             input logic wr, input string what);
        step();
        clear_inputs();
        step();
        check_outputs(data, wreg, wr, what);
    endtask

    task automatic do_store(input logic [31:0] addr, input logic [31:0] data,
                            input mem_width_e w);
        drive_mem(1'b1, addr, data, w, 1'b0);
        record_store(addr, data, w);
        finish_op(addr, 5'd9, 1'b0, "store");
    endtask

    task automatic do_load(input logic [31:0] addr, input mem_width_e w, input logic sign);
        drive_mem(1'b0, addr, 32'h0, w, sign);
        finish_op(expected_load(addr, w, sign), 5'd9, 1'b1, "load");
    endtask

    task automatic check_reset_state();
        check_outputs(32'h0, 5'd0, 1'b0, "after reset");
    endtask

    task automatic run_alu_ops();
        alu_op_e     op;
        logic [3:0]  k;
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  rd;
        int          i;
        for (i = 0; i < 50; i++) begin
            k  = 4'($urandom_range(0, 8));
            op = alu_op_e'(k);
            a  = $urandom;
            b  = $urandom;
            rd = 5'($urandom);
            drive_alu(op, a, b, 5'($urandom), rd);
            finish_op(expected_exec(op, a, b, 5'd0), rd, 1'b1, op.name());
        end
    endtask

    task automatic run_shift_ops();
        alu_op_e     op;
        logic [1:0]  k;
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        logic [4:0]  rd;
        int          i;
        for (i = 0; i < 30; i++) begin
            k  = 2'($urandom_range(0, 2));
            op = (k == 2'd0) ? ALU_SLL : ((k == 2'd1) ? ALU_SRL : ALU_SRA);
            a  = $urandom;
            b  = $urandom;
            sh = 5'($urandom);
            rd = 5'($urandom);
            drive_alu(op, a, b, sh, rd);
            finish_op(expected_exec(op, a, b, sh), rd, 1'b1, op.name());
        end
        // Two shifts in flight at once
        drive_alu(ALU_SRA, 32'h0, 32'h8000_00f0, 5'd4, 5'd1);
        step();
        drive_alu(ALU_SLL, 32'h0, 32'h0000_0f0f, 5'd8, 5'd2);
        step();
        check_outputs(32'hf800_000f, 5'd1, 1'b1, "first in flight");
        clear_inputs();
        step();
        check_outputs(32'h000f_0f00, 5'd2, 1'b1, "second in flight");
    endtask

    task automatic store_then_load(input logic [31:0] st_addr, input logic [31:0] st_data,
                                   input mem_width_e st_w, input logic [31:0] ld_addr,
                                   input mem_width_e ld_w, input logic ld_sign);
        drive_mem(1'b1, st_addr, st_data, st_w, 1'b0);
        record_store(st_addr, st_data, st_w);
        step();
        drive_mem(1'b0, ld_addr, 32'h0, ld_w, ld_sign);
        step();
        check_outputs(st_addr, 5'd9, 1'b0, "store ahead of load");
        clear_inputs();
        step();
        check_outputs(expected_load(ld_addr, ld_w, ld_sign), 5'd9, 1'b1, "load after store");
    endtask

    task automatic exercise_memory_widths();
        logic [31:0] ld_addrs [12];
        mem_width_e  ld_widths [3];
        int          i;
        int          j;
        int          s;
        ld_addrs  = '{32'h40, 32'h41, 32'h42, 32'h43, 32'h45, 32'h46,
                      32'h47, 32'h80, 32'h83, 32'h84, 32'h86, 32'h484};
        ld_widths = '{W_BYTE, W_HALF, W_WORD};
        // Whole words first so that every loaded byte is known
        do_store(32'h40, $urandom, W_WORD);
        do_store(32'h44, $urandom, W_WORD);
        do_store(32'h80, $urandom, W_WORD);
        do_store(32'h84, $urandom, W_WORD);
        do_store(32'h42, 32'h0000_8a5c, W_HALF);
        do_store(32'h81, $urandom, W_HALF);
        do_store(32'h86, 32'h1234_f00d, W_HALF);
        do_store(32'h45, 32'h0000_0093, W_BYTE);
        do_store(32'h47, 32'h0000_0021, W_BYTE);
        // Lands on 0x87 once the bits above the depth drop off
        do_store(32'h487, $urandom, W_BYTE);
        for (i = 0; i < 12; i++) begin
            for (j = 0; j < 3; j++) begin
                for (s = 0; s < 2; s++) begin
                    do_load(ld_addrs[i], ld_widths[j], s[0]);
                end
            end
        end
        // Mem2reg without a read returns zero
        drive_mem(1'b0, 32'h80, 32'h0, W_WORD, 1'b0);
        mem_read = 1'b0;
        finish_op(32'h0, 5'd9, 1'b1, "load without read");
        store_then_load(32'hc0, $urandom, W_WORD, 32'hc2, W_HALF, 1'b1);
        store_then_load(32'hc3, 32'h0000_00f1, W_BYTE, 32'hc0, W_WORD, 1'b0);
    endtask

    task automatic select_destination();
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  rd;
        logic [4:0]  rt;
        int          i;
        for (i = 0; i < 4; i++) begin
            a  = $urandom;
            b  = $urandom;
            rd = 5'($urandom);
            // Keep rt apart from rd so the select is visible
            rt = rd ^ 5'($urandom_range(1, 31));
            drive_alu(ALU_XOR, a, b, 5'd0, rd);
            reg_dst   = i[0];
            rt_num    = rt;
            reg_write = i[1];
            finish_op(a ^ b, i[0] ? rd : rt, i[1], "destination select");
        end
    endtask

    task automatic hold_under_halt();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        int          i;
        a = $urandom;
        b = $urandom;
        c = $urandom;
        d = $urandom;
        drive_alu(ALU_OR, a, b, 5'd0, 5'd3);
        step();
        drive_alu(ALU_SUB, c, d, 5'd0, 5'd4);
        step();
        check_outputs(a | b, 5'd3, 1'b1, "before halt");
        // SUB waits in EX/MEM while a store sits on the inputs
        halt = 1'b1;
        drive_mem(1'b1, 32'h44, $urandom, W_WORD, 1'b0);
        for (i = 0; i < 5; i++) begin
            step();
            check_outputs(a | b, 5'd3, 1'b1, "during halt");
            data4mem = $urandom;
            rd_num   = 5'($urandom);
        end
        halt = 1'b0;
        clear_inputs();
        step();
        check_outputs(expected_exec(ALU_SUB, c, d, 5'd0), 5'd4, 1'b1, "after halt");
        do_load(32'h44, W_WORD, 1'b0);
    endtask

    initial begin
        void'($urandom(1));
        clear_inputs();
        halt  = 1'b0;
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_reset_state();
        run_alu_ops();
        run_shift_ops();
        exercise_memory_widths();
        select_destination();
        hold_under_halt();
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/ex_mem_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mips_config.svh"

module ex_mem_top
    import mips_pkg::*;
(
    input  wire                       clk,
    input  wire                       i_rst_n,
    input  wire                       i_halt,

    // Decoded operands
    input  wire alu_op_e              i_alu_op,
    input  wire [`NB_DATA-1:0]        i_operand_a,
    input  wire [`NB_DATA-1:0]        i_operand_b,
    input  wire [4:0]                 i_shamt,
    input  wire [`NB_DATA-1:0]        i_data4mem,

    // Control from decode
    input  wire                       i_mem2reg,
    input  wire                       i_mem_read,
    input  wire                       i_mem_write,
    input  wire                       i_reg_write,
    input  wire mem_width_e           i_width,
    input  wire                       i_sign_flag,
    input  wire                       i_reg_dst,
    input  wire [`NB_REG-1:0]         i_rd,
    input  wire [`NB_REG-1:0]         i_rt,

    // Write-back
    output logic [`NB_DATA-1:0]       o_wb_data,
    output logic [`NB_REG-1:0]        o_write_reg,
    output logic                      o_reg_write
);

    logic [`NB_DATA-1:0]   alu_result;
    logic [`NB_DATA-1:0]   shift_result;

    // EX/MEM to memory stage
    logic [`NB_DATA-1:0]   em_result;
    logic [`NB_DATA-1:0]   em_data4mem;
    logic                  em_mem2reg;
    logic                  em_mem_read;
    logic                  em_mem_write;
    logic                  em_reg_write;
    mem_width_e            em_width;
    logic                  em_sign_flag;
    logic [`NB_REG-1:0]    em_write_reg;

    alu_unit alu_unit_i (
        .i_alu_op    (i_alu_op),
        .i_operand_a (i_operand_a),
        .i_operand_b (i_operand_b),
        .o_result    (alu_result)
    );

    shift_unit shift_unit_i (
        .i_alu_op    (i_alu_op),
        .i_operand_b (i_operand_b),
        .i_shamt     (i_shamt),
        .o_result    (shift_result)
    );

    exmem_reg exmem_reg_i (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_halt         (i_halt),
        .i_alu_op       (i_alu_op),
        .i_alu_result   (alu_result),
        .i_shift_result (shift_result),
        .i_data4mem     (i_data4mem),
        .i_mem2reg      (i_mem2reg),
        .i_mem_read     (i_mem_read),
        .i_mem_write    (i_mem_write),
        .i_reg_write    (i_reg_write),
        .i_width        (i_width),
        .i_sign_flag    (i_sign_flag),
        .i_reg_dst      (i_reg_dst),
        .i_rd           (i_rd),
        .i_rt           (i_rt),
        .o_result       (em_result),
        .o_data4mem     (em_data4mem),
        .o_mem2reg      (em_mem2reg),
        .o_mem_read     (em_mem_read),
        .o_mem_write    (em_mem_write),
        .o_reg_write    (em_reg_write),
        .o_width        (em_width),
        .o_sign_flag    (em_sign_flag),
        .o_write_reg    (em_write_reg)
    );

    data_mem data_mem_i (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_halt         (i_halt),
        .i_addr         (em_result),
        .i_store_data   (em_data4mem),
        .i_mem_read     (em_mem_read),
        .i_mem_write    (em_mem_write),
        .i_mem2reg      (em_mem2reg),
        .i_reg_write    (em_reg_write),
        .i_width        (em_width),
        .i_sign_flag    (em_sign_flag),
        .i_write_reg    (em_write_reg),
        .o_wb_data      (o_wb_data),
        .o_wb_reg       (o_write_reg),
        .o_wb_reg_write (o_reg_write)
    );

endmodule

`default_nettype wire

// ==== hw/data_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mips_config.svh"

module data_mem
    import mips_pkg::*;
(
    input  wire                       clk,
    input  wire                       i_rst_n,
    input  wire                       i_halt,

    // Byte address and store data from EX/MEM
    input  wire [`NB_DATA-1:0]        i_addr,
    input  wire [`NB_DATA-1:0]        i_store_data,

    input  wire                       i_mem_read,
    input  wire                       i_mem_write,
    input  wire                       i_mem2reg,
    input  wire                       i_reg_write,
    input  wire mem_width_e           i_width,
    input  wire                       i_sign_flag,
    input  wire [`NB_REG-1:0]         i_write_reg,

    // MEM/WB register outputs
    output logic [`NB_DATA-1:0]       o_wb_data,
    output logic [`NB_REG-1:0]        o_wb_reg,
    output logic                      o_wb_reg_write
);

    localparam int ADDR_W = $clog2(`MEM_WORDS);

    logic [`NB_DATA-1:0]   mem [`MEM_WORDS];

    logic [ADDR_W-1:0]     word_idx;
    logic [1:0]            lane;
    logic [3:0]            byte_en;
    logic [`NB_DATA-1:0]   wr_data;
    logic [`NB_DATA-1:0]   rd_word;
    logic [7:0]            rd_byte;
    logic [15:0]           rd_half;
    logic [`NB_DATA-1:0]   load_data;

    // Upper address bits beyond the array depth are dropped
    assign word_idx = i_addr[ADDR_W+1:2];
    assign lane     = i_addr[1:0];

    // Store lane enables, data replicated so every lane sees its slice
    always_comb begin
        case (i_width)
            W_BYTE: begin
                byte_en = 4'b0001 << lane;
                wr_data = {4{i_store_data[7:0]}};
            end
            W_HALF: begin
                byte_en = lane[1] ? 4'b1100 : 4'b0011;
                wr_data = {2{i_store_data[15:0]}};
            end
            default: begin
                byte_en = 4'b1111;
                wr_data = i_store_data;
            end
        endcase
    end

    // Only the enabled lanes are updated
    always_ff @(posedge clk) begin
        if (i_mem_write && !i_halt) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i]) begin
                    mem[word_idx][8*i +: 8] <= wr_data[8*i +: 8];
                end
            end
        end
    end

    // Asynchronous read of the addressed word
    assign rd_word = mem[word_idx];

    always_comb begin
        case (lane)
            2'd0:    rd_byte = rd_word[7:0];
            2'd1:    rd_byte = rd_word[15:8];
            2'd2:    rd_byte = rd_word[23:16];
            default: rd_byte = rd_word[31:24];
        endcase
    end

    // Bit 0 of the address is ignored for half-words
    assign rd_half = lane[1] ? rd_word[31:16] : rd_word[15:0];

    // Load extension, zero when no read is in progress
    always_comb begin
        if (!i_mem_read) begin
            load_data = '0;
        end else begin
            case (i_width)
                W_BYTE: begin
                    load_data = {{24{i_sign_flag & rd_byte[7]}}, rd_byte};
                end
                W_HALF: begin
                    load_data = {{16{i_sign_flag & rd_half[15]}}, rd_half};
                end
                default: begin
                    load_data = rd_word;
                end
            endcase
        end
    end

    // MEM/WB register
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb_data      <= '0;
            o_wb_reg       <= '0;
            o_wb_reg_write <= 1'b0;
        end else if (!i_halt) begin
            o_wb_data      <= i_mem2reg ? load_data : i_addr;
            o_wb_reg       <= i_write_reg;
            o_wb_reg_write <= i_reg_write;
        end
    end

endmodule

`default_nettype wire

// ==== hw/exmem_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mips_config.svh"

module exmem_reg
    import mips_pkg::*;
(
    input  wire                       clk,
    input  wire                       i_rst_n,
    input  wire                       i_halt,

    // Execute results and store data
    input  wire alu_op_e              i_alu_op,
    input  wire [`NB_DATA-1:0]        i_alu_result,
    input  wire [`NB_DATA-1:0]        i_shift_result,
    input  wire [`NB_DATA-1:0]        i_data4mem,

    // Memory and write-back control
    input  wire                       i_mem2reg,
    input  wire                       i_mem_read,
    input  wire                       i_mem_write,
    input  wire                       i_reg_write,
    input  wire mem_width_e           i_width,
    input  wire                       i_sign_flag,

    // Destination register candidates
    input  wire                       i_reg_dst,
    input  wire [`NB_REG-1:0]         i_rd,
    input  wire [`NB_REG-1:0]         i_rt,

    output logic [`NB_DATA-1:0]       o_result,
    output logic [`NB_DATA-1:0]       o_data4mem,
    output logic                      o_mem2reg,
    output logic                      o_mem_read,
    output logic                      o_mem_write,
    output logic                      o_reg_write,
    output mem_width_e                o_width,
    output logic                      o_sign_flag,
    output logic [`NB_REG-1:0]        o_write_reg
);

    logic                  is_shift;
    logic [`NB_DATA-1:0]   ex_result;
    logic [`NB_REG-1:0]    dest_reg;

    // Shift class opcodes take the shift unit result
    assign is_shift  = (i_alu_op == ALU_SLL) || (i_alu_op == ALU_SRL) ||
                       (i_alu_op == ALU_SRA);
    assign ex_result = is_shift ? i_shift_result : i_alu_result;

    // R-type writes rd, I-type writes rt
    assign dest_reg  = i_reg_dst ? i_rd : i_rt;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_result    <= '0;
            o_data4mem  <= '0;
            o_mem2reg   <= 1'b0;
            o_mem_read  <= 1'b0;
            o_mem_write <= 1'b0;
            o_reg_write <= 1'b0;
            o_width     <= W_WORD;
            o_sign_flag <= 1'b0;
            o_write_reg <= '0;
        end else if (!i_halt) begin
            o_result    <= ex_result;
            o_data4mem  <= i_data4mem;
            o_mem2reg   <= i_mem2reg;
            o_mem_read  <= i_mem_read;
            o_mem_write <= i_mem_write;
            o_reg_write <= i_reg_write;
            o_width     <= i_width;
            o_sign_flag <= i_sign_flag;
            o_write_reg <= dest_reg;
        end
    end

endmodule

`default_nettype wire

// ==== hw/shift_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mips_config.svh"

module shift_unit
    import mips_pkg::*;
(
    input  wire alu_op_e              i_alu_op,
    input  wire [`NB_DATA-1:0]        i_operand_b,
    input  wire [4:0]                 i_shamt,
    output logic [`NB_DATA-1:0]       o_result
);

    // MIPS shifts act on rt, which arrives as operand B
    always_comb begin
        case (i_alu_op)
            ALU_SLL: begin
                o_result = i_operand_b << i_shamt;
            end
            ALU_SRL: begin
                o_result = i_operand_b >> i_shamt;
            end
            // Sign bit is replicated into the vacated positions
            ALU_SRA: begin
                o_result = $signed(i_operand_b) >>> i_shamt;
            end
            // Everything else is an ALU operation
            default: begin
                o_result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/alu_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mips_config.svh"

module alu_unit
    import mips_pkg::*;
(
    input  wire alu_op_e              i_alu_op,
    input  wire [`NB_DATA-1:0]        i_operand_a,
    input  wire [`NB_DATA-1:0]        i_operand_b,
    output logic [`NB_DATA-1:0]       o_result
);

    // Signed and unsigned comparisons for the set-less-than pair
    logic lt_signed;
    logic lt_unsigned;

    assign lt_signed   = $signed(i_operand_a) < $signed(i_operand_b);
    assign lt_unsigned = i_operand_a < i_operand_b;

    always_comb begin
        case (i_alu_op)
            // Add and subtract wrap on overflow
            ALU_ADD: begin
                o_result = i_operand_a + i_operand_b;
            end
            ALU_SUB: begin
                o_result = i_operand_a - i_operand_b;
            end
            ALU_AND: begin
                o_result = i_operand_a & i_operand_b;
            end
            ALU_OR: begin
                o_result = i_operand_a | i_operand_b;
            end
            ALU_XOR: begin
                o_result = i_operand_a ^ i_operand_b;
            end
            ALU_NOR: begin
                o_result = ~(i_operand_a | i_operand_b);
            end
            ALU_SLT: begin
                o_result = {{(`NB_DATA-1){1'b0}}, lt_signed};
            end
            ALU_SLTU: begin
                o_result = {{(`NB_DATA-1){1'b0}}, lt_unsigned};
            end
            // Immediate sits in the low half of operand B
            ALU_LUI: begin
                o_result = {i_operand_b[15:0], 16'h0000};
            end
            // Shift opcodes belong to shift_unit
            default: begin
                o_result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    // Execute operation shared by the ALU and the shift unit
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_SLT  = 4'd6,
        ALU_SLTU = 4'd7,
        ALU_LUI  = 4'd8,
        // Shift class, handled by shift_unit
        ALU_SLL  = 4'd9,
        ALU_SRL  = 4'd10,
        ALU_SRA  = 4'd11
    } alu_op_e;

    // Data memory access size
    // 2'b10 is unused and treated as a word access
    typedef enum logic [1:0] {
        W_BYTE = 2'b00,
        W_HALF = 2'b01,
        W_WORD = 2'b11
    } mem_width_e;

endpackage

`default_nettype wire

// ==== hw/mips_config.svh ====
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// Datapath width in bits
`define NB_DATA 32

// Register-number width, 32 architectural registers
`define NB_REG 5

// Data memory depth in 32-bit words
`define MEM_WORDS 256

`endif
